// ==== hw/line_buffer_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_buffer_port import sprite_pkg::*; #(
	parameter int LINE_LENGTH = 353
) (
	input logic clk,
	input logic reset,
	input logic swap,
	input logic clear_start,
	input logic pixel_start,
	input logic write,
	input logic advance,
	input pos_t x,
	input argb_t pixel_data,
	input pos_t hcnt,
	output lb_write_t lb_wr,
	output logic clear_done,
	output lb_addr_t lb_rd_addr,
	input argb_t lb_rd_data,
	output logic [7:0] spr_r,
	output logic [7:0] spr_g,
	output logic [7:0] spr_b,
	output logic spr_a
);

	localparam pos_t CLEAR_LAST = pos_t'(LINE_LENGTH - 1);

	logic rd_slot;
	logic wr_slot;
	logic clearing;

	assign clear_done = clearing && (lb_wr.addr[8:0] == CLEAR_LAST);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_slot <= 1'b0;
			wr_slot <= 1'b1;
			clearing <= 1'b0;
			lb_wr.wr <= 1'b0;
		end
		else
		begin
			if (swap)
			begin
				rd_slot <= ~rd_slot;
				wr_slot <= ~wr_slot;
			end
			if (clear_start)
			begin
				clearing <= 1'b1;
				lb_wr.wr <= 1'b1;
				lb_wr.addr <= {wr_slot, 9'd0};
				lb_wr.data <= '0;
			end
			else if (clear_done)
			begin
				clearing <= 1'b0;
				lb_wr.wr <= 1'b0;
			end
			else if (clearing)
				lb_wr.addr <= {lb_wr.addr[9], lb_wr.addr[8:0] + 9'd1};
			else if (pixel_start)
			begin
				lb_wr.wr <= 1'b0;
				lb_wr.addr <= {wr_slot, x};
			end
			else if (write)
			begin
				lb_wr.wr <= 1'b1;
				lb_wr.data <= pixel_data;
			end
			else if (advance)
			begin
				// Position wraps inside the slot
				lb_wr.wr <= 1'b0;
				lb_wr.addr <= {lb_wr.addr[9], lb_wr.addr[8:0] + 9'd1};
			end
		end
	end

	assign lb_rd_addr = {rd_slot, hcnt + LB_READ_SKEW};

	// 5 to 8 bits by repeating the top bits
	assign spr_r = {lb_rd_data.red, lb_rd_data.red[4:2]};
	assign spr_g = {lb_rd_data.green, lb_rd_data.green[4:2]};
	assign spr_b = {lb_rd_data.blue, lb_rd_data.blue[4:2]};
	assign spr_a = lb_rd_data.alpha;

endmodule

`default_nettype wire

// ==== hw/sprite_attr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_attr_unit import sprite_pkg::*; (
	input logic clk,
	input logic reset,
	input logic line_start,
	input logic rec_start,
	input logic load_hi,
	input logic load_lo,
	input logic [7:0] sram_data,
	input pos_t vcnt,
	input logic [7:0] rom_data,
	output sprite_attr_t attr,
	output logic hit,
	output pos_t row,
	output pal_addr_t pal_addr
);

	pos_t active_line;
	// Low for the y byte pair, high for the x byte pair
	logic x_half;

	always_ff @(posedge clk)
	begin
		if (reset)
			x_half <= 1'b0;
		else if (rec_start)
			x_half <= 1'b0;
		else if (load_lo)
			x_half <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (line_start)
			active_line <= vcnt + 9'd1;
		if (load_hi && !x_half)
		begin
			attr.enable <= sram_data[7];
			attr.palette <= sram_data[5:4];
			attr.size <= size_e'(sram_data[3:2]);
			attr.y[8] <= sram_data[0];
		end
		if (load_hi && x_half)
		begin
			attr.image <= sram_data[7:2];
			attr.x[8] <= sram_data[0];
		end
		if (load_lo && !x_half)
			attr.y[7:0] <= sram_data;
		if (load_lo && x_half)
			attr.x[7:0] <= sram_data;
	end

	assign row = active_line - attr.y;
	assign hit = attr.enable && (attr.size != SIZE_NONE) && (active_line >= attr.y)
		&& (row < size_px(attr.size));

	// Image byte low bits pick the entry within the sprite palette
	assign pal_addr = {attr.palette, rom_data[4:0]};

endmodule

`default_nettype wire

// ==== hw/sprite_line_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_line_top import sprite_pkg::*; #(
	parameter int NUM_SPRITES = 32,
	parameter int LINE_LENGTH = 353
) (
	input logic clk,
	input logic reset,
	input logic hsync,
	input pos_t hcnt,
	input pos_t vcnt,
	output sram_addr_t sram_addr,
	input logic [7:0] sram_data,
	output rom_addr_t rom_addr,
	input logic [7:0] rom_data,
	output pal_addr_t pal_addr,
	input argb_t pal_data,
	output lb_write_t lb_wr,
	output lb_addr_t lb_rd_addr,
	input argb_t lb_rd_data,
	output logic [7:0] spr_r,
	output logic [7:0] spr_g,
	output logic [7:0] spr_b,
	output logic spr_a
);

	logic attr_rec_start;
	logic attr_load_hi;
	logic attr_load_lo;
	logic rom_load_table;
	logic rom_row_start;
	logic rom_step;
	logic lb_swap;
	logic lb_clear_start;
	logic lb_pixel_start;
	logic lb_write;
	logic lb_advance;
	logic clear_done;
	logic hit;
	sprite_attr_t attr;
	pos_t row;

	sprite_sequencer #(
		.NUM_SPRITES(NUM_SPRITES)
	) u_sequencer (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.attr_rec_start(attr_rec_start),
		.attr_load_hi(attr_load_hi),
		.attr_load_lo(attr_load_lo),
		.rom_load_table(rom_load_table),
		.rom_row_start(rom_row_start),
		.rom_step(rom_step),
		.lb_swap(lb_swap),
		.lb_clear_start(lb_clear_start),
		.lb_pixel_start(lb_pixel_start),
		.lb_write(lb_write),
		.lb_advance(lb_advance),
		.hit(hit),
		.clear_done(clear_done),
		.size(attr.size),
		.pal_alpha(pal_data.alpha),
		.sram_addr(sram_addr)
	);

	// The swap strobe doubles as the line start for the active line latch
	sprite_attr_unit u_attr (
		.clk(clk),
		.reset(reset),
		.line_start(lb_swap),
		.rec_start(attr_rec_start),
		.load_hi(attr_load_hi),
		.load_lo(attr_load_lo),
		.sram_data(sram_data),
		.vcnt(vcnt),
		.rom_data(rom_data),
		.attr(attr),
		.hit(hit),
		.row(row),
		.pal_addr(pal_addr)
	);

	sprite_rom_addr_gen u_rom_addr (
		.clk(clk),
		.reset(reset),
		.rom_data(rom_data),
		.load_table(rom_load_table),
		.row_start(rom_row_start),
		.step(rom_step),
		.size(attr.size),
		.image(attr.image),
		.row(row),
		.rom_addr(rom_addr)
	);

	line_buffer_port #(
		.LINE_LENGTH(LINE_LENGTH)
	) u_lb_port (
		.clk(clk),
		.reset(reset),
		.swap(lb_swap),
		.clear_start(lb_clear_start),
		.pixel_start(lb_pixel_start),
		.write(lb_write),
		.advance(lb_advance),
		.x(attr.x),
		.pixel_data(pal_data),
		.hcnt(hcnt),
		.lb_wr(lb_wr),
		.clear_done(clear_done),
		.lb_rd_addr(lb_rd_addr),
		.lb_rd_data(lb_rd_data),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a)
	);

endmodule

`default_nettype wire

// ==== hw/sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

	// Screen coordinate that also serves counters and the active line
	typedef logic [8:0] pos_t;

	// Line buffer address is the slot bit above a screen position
	typedef logic [9:0] lb_addr_t;
	typedef logic [13:0] rom_addr_t;
	typedef logic [6:0] sram_addr_t;
	typedef logic [4:0] sprite_idx_t;
	typedef logic [6:0] pal_addr_t;

	typedef struct packed {
		logic alpha;
		logic [4:0] blue;
		logic [4:0] green;
		logic [4:0] red;
	} argb_t;

	typedef enum logic [1:0] {
		SIZE_32 = 2'd0,
		SIZE_16 = 2'd1,
		SIZE_8 = 2'd2,
		SIZE_NONE = 2'd3
	} size_e;

	typedef struct packed {
		logic enable;
		logic [1:0] palette;
		size_e size;
		logic [5:0] image;
		pos_t x;
		pos_t y;
	} sprite_attr_t;

	typedef struct packed {
		logic wr;
		lb_addr_t addr;
		argb_t data;
	} lb_write_t;

	// Read side runs ahead of the visible counter
	localparam pos_t LB_READ_SKEW = 9'd32;

	// Edge length in pixels or zero for a sprite that is not drawn
	function automatic pos_t size_px(size_e size);
		case (size)
			SIZE_32: return 9'd32;
			SIZE_16: return 9'd16;
			SIZE_8: return 9'd8;
			default: return 9'd0;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hw/sprite_rom_addr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_rom_addr_gen import sprite_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [7:0] rom_data,
	input logic load_table,
	input logic row_start,
	input logic step,
	input size_e size,
	input logic [5:0] image,
	input pos_t row,
	output rom_addr_t rom_addr
);

	// Indexed by size code with 32x32 first
	rom_addr_t offset_tbl [0:2];
	rom_addr_t base;
	rom_addr_t image_off;
	rom_addr_t row_off;

	// Table bytes are big-endian with the upper 6 bits at the even address
	always_ff @(posedge clk)
	begin
		if (load_table && !rom_addr[0])
			offset_tbl[rom_addr[2:1]][13:8] <= rom_data[5:0];
		if (load_table && rom_addr[0])
			offset_tbl[rom_addr[2:1]][7:0] <= rom_data;
	end

	always_comb
	begin
		case (size)
			SIZE_32:
			begin
				// Each image takes 1 KiB so only 16 fit
				base = offset_tbl[0];
				image_off = {image[3:0], 10'd0};
				row_off = {4'd0, row[4:0], 5'd0};
			end
			SIZE_16:
			begin
				base = offset_tbl[1];
				image_off = {image, 8'd0};
				row_off = {6'd0, row[3:0], 4'd0};
			end
			default:
			begin
				base = offset_tbl[2];
				image_off = {2'd0, image, 6'd0};
				row_off = {8'd0, row[2:0], 3'd0};
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rom_addr <= '0;
		else if (load_table || step)
			rom_addr <= rom_addr + 14'd1;
		else if (row_start)
			rom_addr <= base + image_off + row_off;
	end

endmodule

`default_nettype wire

// ==== hw/sprite_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_sequencer import sprite_pkg::*; #(
	parameter int NUM_SPRITES = 32
) (
	input logic clk,
	input logic reset,
	input logic hsync,
	output logic attr_rec_start,
	output logic attr_load_hi,
	output logic attr_load_lo,
	output logic rom_load_table,
	output logic rom_row_start,
	output logic rom_step,
	output logic lb_swap,
	output logic lb_clear_start,
	output logic lb_pixel_start,
	output logic lb_write,
	output logic lb_advance,
	input logic hit,
	input logic clear_done,
	input size_e size,
	input logic pal_alpha,
	output sram_addr_t sram_addr
);

	typedef enum logic [4:0] {
		S_LOAD_WAIT,
		S_LOAD_CAP,
		S_IDLE,
		S_SWAP,
		S_CLEAR_START,
		S_CLEAR,
		S_REC_ADDR,
		S_REC_HI,
		S_REC_LO,
		S_HIT_CHECK,
		S_X_HI,
		S_X_LO,
		S_ROW_SETUP,
		S_FETCH,
		S_STAGE,
		S_WRITE,
		S_NEXT,
		S_WAIT
	} state_e;

	localparam sprite_idx_t LAST_IDX = sprite_idx_t'(NUM_SPRITES - 1);

	state_e state;
	state_e ret_state;
	logic [2:0] load_cnt;
	sprite_idx_t idx;
	pos_t pix_cnt;
	logic hsync_last;
	logic hsync_rise;
	logic pixel_last;

	assign hsync_rise = hsync && !hsync_last;
	assign pixel_last = (pix_cnt == size_px(size) - 9'd1);

	// Datapath strobes decode straight from the state
	assign attr_rec_start = (state == S_REC_ADDR);
	assign attr_load_hi = (state == S_REC_HI) || (state == S_X_HI);
	assign attr_load_lo = (state == S_REC_LO) || (state == S_X_LO);
	assign rom_load_table = (state == S_LOAD_CAP);
	assign rom_row_start = (state == S_ROW_SETUP);
	assign rom_step = (state == S_FETCH);
	assign lb_swap = (state == S_SWAP);
	assign lb_clear_start = (state == S_CLEAR_START);
	assign lb_pixel_start = (state == S_ROW_SETUP);
	assign lb_write = (state == S_STAGE) && pal_alpha;
	assign lb_advance = (state == S_WRITE);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_LOAD_WAIT;
			ret_state <= S_IDLE;
			load_cnt <= '0;
			idx <= '0;
			pix_cnt <= '0;
			hsync_last <= 1'b0;
		end
		else
		begin
			hsync_last <= hsync;
			case (state)
				S_LOAD_WAIT: state <= S_LOAD_CAP;
				S_LOAD_CAP:
				begin
					// Six table bytes make three offsets
					if (load_cnt == 3'd5)
						state <= S_IDLE;
					else
					begin
						load_cnt <= load_cnt + 3'd1;
						state <= S_LOAD_WAIT;
					end
				end
				S_IDLE:
				begin
					if (hsync_rise)
						state <= S_SWAP;
				end
				S_SWAP:
				begin
					idx <= '0;
					state <= S_CLEAR_START;
				end
				S_CLEAR_START: state <= S_CLEAR;
				S_CLEAR:
				begin
					if (clear_done)
						state <= S_REC_ADDR;
				end
				S_REC_ADDR:
				begin
					ret_state <= S_REC_HI;
					state <= S_WAIT;
				end
				S_REC_HI:
				begin
					ret_state <= S_REC_LO;
					state <= S_WAIT;
				end
				S_REC_LO: state <= S_HIT_CHECK;
				// Byte 2 read completes during this cycle
				S_HIT_CHECK: state <= hit ? S_X_HI : S_NEXT;
				S_X_HI:
				begin
					ret_state <= S_X_LO;
					state <= S_WAIT;
				end
				S_X_LO: state <= S_ROW_SETUP;
				S_ROW_SETUP:
				begin
					pix_cnt <= '0;
					ret_state <= S_FETCH;
					state <= S_WAIT;
				end
				S_FETCH: state <= S_STAGE;
				S_STAGE: state <= S_WRITE;
				S_WRITE:
				begin
					if (pixel_last)
						state <= S_NEXT;
					else
					begin
						pix_cnt <= pix_cnt + 9'd1;
						state <= S_FETCH;
					end
				end
				S_NEXT:
				begin
					if (idx == LAST_IDX)
						state <= S_IDLE;
					else
					begin
						idx <= idx + 5'd1;
						state <= S_REC_ADDR;
					end
				end
				S_WAIT: state <= ret_state;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Record address walks the four bytes of the current sprite
	always_ff @(posedge clk)
	begin
		if (state == S_REC_ADDR)
			sram_addr <= {idx, 2'b00};
		else if (state == S_REC_HI || state == S_REC_LO || state == S_X_HI)
			sram_addr <= sram_addr + 7'd1;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sprite line testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_sprite_line \
	-f sprite_line.f --Mdir obj_dir -o sim_sprite_line
./obj_dir/sim_sprite_line > sim.log
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi

// ==== sprite_line.f ====
hw/sprite_pkg.sv
hw/sprite_sequencer.sv
hw/sprite_attr_unit.sv
hw/sprite_rom_addr_gen.sv
hw/line_buffer_port.sv
hw/sprite_line_top.sv
test/tb_memories.sv
test/tb_sprite_line.sv

// ==== test/tb_memories.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_memories import sprite_pkg::*; (
	input logic clk,
	input sram_addr_t sram_addr,
	output logic [7:0] sram_data,
	input rom_addr_t rom_addr,
	output logic [7:0] rom_data,
	input pal_addr_t pal_addr,
	output argb_t pal_data,
	input lb_write_t lb_wr,
	input lb_addr_t lb_rd_addr,
	output argb_t lb_rd_data
);

	logic [7:0] sram [0:127];
	logic [7:0] rom [0:16383];
	argb_t pal [0:127];
	// Two slots of 512 entries
	argb_t lb [0:1023];

	// Sprite ROM and palette are filled by the testbench
	initial
	begin
		for (int i = 0; i < 128; i++)
			sram[sram_addr_t'(i)] = 8'h00;
		for (int i = 0; i < 1024; i++)
			lb[lb_addr_t'(i)] = '0;
	end

	// All reads have one cycle of latency
	always @(posedge clk)
	begin
		sram_data <= sram[sram_addr];
		rom_data <= rom[rom_addr];
		pal_data <= pal[pal_addr];
		lb_rd_data <= lb[lb_rd_addr];
		// Line buffer write follows the read of the same cycle
		if (lb_wr.wr)
			lb[lb_wr.addr] = lb_wr.data;
	end

endmodule

`default_nettype wire

// ==== test/tb_sprite_line.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sprite_line import sprite_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int NUM_SPRITES = 32;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 6000;
	localparam int LINE_WAIT = 4000;
	// Sweep plus the time the second render needs before records change
	localparam int SETTLE_CYCLES = 1500;
	localparam pos_t READ_SKEW = 9'd32;

	logic clk;
	logic reset;
	logic hsync;
	pos_t hcnt;
	pos_t vcnt;
	sram_addr_t sram_addr;
	logic [7:0] sram_data;
	rom_addr_t rom_addr;
	logic [7:0] rom_data;
	pal_addr_t pal_addr;
	argb_t pal_data;
	lb_write_t lb_wr;
	lb_addr_t lb_rd_addr;
	argb_t lb_rd_data;
	logic [7:0] spr_r;
	logic [7:0] spr_g;
	logic [7:0] spr_b;
	logic spr_a;

	int seed;
	int checks;
	int errors;
	int test_errors;
	int failed_tests;

	sprite_line_top #(
		.NUM_SPRITES(NUM_SPRITES),
		.LINE_LENGTH(353)
	) u_sprite_line_top (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.sram_addr(sram_addr),
		.sram_data(sram_data),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.lb_wr(lb_wr),
		.lb_rd_addr(lb_rd_addr),
		.lb_rd_data(lb_rd_data),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a)
	);

	tb_memories u_mem (
		.clk(clk),
		.sram_addr(sram_addr),
		.sram_data(sram_data),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.lb_wr(lb_wr),
		.lb_rd_addr(lb_rd_addr),
		.lb_rd_data(lb_rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog over the budget of all tests
	initial
	begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic int size_len(logic [1:0] code);
		case (code)
			2'd0: return 32;
			2'd1: return 16;
			2'd2: return 8;
			default: return 0;
		endcase
	endfunction

	function automatic logic [7:0] widen(logic [4:0] c);
		return {c, c[4:2]};
	endfunction

	// Expected line buffer entry at a position for the given active line
	function automatic argb_t ref_pixel(pos_t pos, pos_t line);
		argb_t result;
		argb_t color;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [13:0] offset;
		rom_addr_t addr;
		int len;
		int row;
		int col;
		int image_off;
		result = '0;
		for (int i = 0; i < NUM_SPRITES; i++)
		begin
			b0 = u_mem.sram[sram_addr_t'(4 * i)];
			b1 = u_mem.sram[sram_addr_t'(4 * i + 1)];
			b2 = u_mem.sram[sram_addr_t'(4 * i + 2)];
			b3 = u_mem.sram[sram_addr_t'(4 * i + 3)];
			len = size_len(b0[3:2]);
			row = int'(line) - int'({b0[0], b1});
			// Columns wrap at 9 bits
			col = (int'(pos) - int'({b2[0], b3}) + 512) % 512;
			if (b0[7] && len > 0 && row >= 0 && row < len && col < len)
			begin
				offset = {u_mem.rom[rom_addr_t'(2 * b0[3:2])][5:0],
					u_mem.rom[rom_addr_t'(2 * b0[3:2] + 1)]};
				if (len == 32)
					image_off = int'(b2[5:2]) * 1024;
				else
					image_off = int'(b2[7:2]) * len * len;
				addr = rom_addr_t'(int'(offset) + image_off + row * len + col);
				color = u_mem.pal[{b0[5:4], u_mem.rom[addr][4:0]}];
				if (color.alpha)
					result = color;
			end
		end
		return result;
	endfunction

	task automatic check_rgb(string name, pos_t h, logic [7:0] expected, logic [7:0] actual);
		checks = checks + 1;
		if (actual !== expected)
		begin
			test_errors = test_errors + 1;
			$display("[ERROR] %s at hcnt %0d: expected %h, got %h", name, h, expected, actual);
		end
	endtask

	task automatic check_alpha(pos_t h, logic expected, logic actual);
		checks = checks + 1;
		if (actual !== expected)
		begin
			test_errors = test_errors + 1;
			$display("[ERROR] spr_a at hcnt %0d: expected %h, got %h", h, expected, actual);
		end
	endtask

	task automatic fill_memories();
		for (int i = 0; i < 16384; i++)
			u_mem.rom[rom_addr_t'(i)] = 8'($random(seed));
		for (int i = 0; i < 128; i++)
			u_mem.pal[pal_addr_t'(i)] = 16'($random(seed));
		// Offsets 0x2000, 0x1000 and 0x0840 with the top two bits ignored
		u_mem.rom[14'd0] = 8'hA0;
		u_mem.rom[14'd1] = 8'h00;
		u_mem.rom[14'd2] = 8'h10;
		u_mem.rom[14'd3] = 8'h00;
		u_mem.rom[14'd4] = 8'h08;
		u_mem.rom[14'd5] = 8'h40;
	endtask

	task automatic clear_records();
		for (int i = 0; i < 4 * NUM_SPRITES; i++)
			u_mem.sram[sram_addr_t'(i)] = 8'h00;
	endtask

	task automatic put_sprite(int idx, logic en, logic [1:0] palette, logic [1:0] code,
		logic [5:0] image, pos_t x, pos_t y);
		u_mem.sram[sram_addr_t'(4 * idx)] = {en, 1'b0, palette, code, 1'b0, y[8]};
		u_mem.sram[sram_addr_t'(4 * idx + 1)] = y[7:0];
		u_mem.sram[sram_addr_t'(4 * idx + 2)] = {image, 1'b0, x[8]};
		u_mem.sram[sram_addr_t'(4 * idx + 3)] = x[7:0];
	endtask

	task automatic pulse_hsync();
		@(posedge clk);
		hsync <= 1'b1;
		@(posedge clk);
		hsync <= 1'b0;
	endtask

	// Read data is registered and is sampled at the falling edge after it arrives
	task automatic sweep(int first, int last);
		argb_t expected;
		pos_t line;
		pos_t pos;
		line = vcnt + 9'd1;
		for (int h = first; h <= last; h++)
		begin
			@(posedge clk);
			hcnt <= pos_t'(h);
			@(posedge clk);
			@(negedge clk);
			pos = pos_t'(h) + READ_SKEW;
			expected = ref_pixel(pos, line);
			check_rgb("spr_r", pos_t'(h), widen(expected.red), spr_r);
			check_rgb("spr_g", pos_t'(h), widen(expected.green), spr_g);
			check_rgb("spr_b", pos_t'(h), widen(expected.blue), spr_b);
			check_alpha(pos_t'(h), expected.alpha, spr_a);
		end
	endtask

	task automatic run_line(int num, string name, pos_t v, int last_h);
		test_errors = 0;
		@(posedge clk);
		vcnt <= v;
		pulse_hsync();
		repeat (LINE_WAIT) @(posedge clk);
		// Second edge moves the rendered half to the read side
		pulse_hsync();
		sweep(0, last_h);
		repeat (SETTLE_CYCLES - 2 * (last_h + 1)) @(posedge clk);
		errors = errors + test_errors;
		if (test_errors == 0)
			$display("test %0d %s: ok", num, name);
		else
		begin
			failed_tests = failed_tests + 1;
			$display("test %0d %s: %0d errors", num, name, test_errors);
		end
	endtask

	initial
	begin
		seed = 47791;
		checks = 0;
		errors = 0;
		test_errors = 0;
		failed_tests = 0;
		reset <= 1'b1;
		hsync <= 1'b0;
		hcnt <= '0;
		vcnt <= '0;
		fill_memories();
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// Offset table load needs 13 cycles
		repeat (20) @(posedge clk);

		@(negedge clk);
		clear_records();
		put_sprite(3, 1'b1, 2'd1, 2'd2, 6'd5, 9'd100, 9'd50);
		run_line(1, "single 8x8", 9'd52, 319);

		@(negedge clk);
		clear_records();
		put_sprite(0, 1'b1, 2'd2, 2'd1, 6'd9, 9'd60, 9'd40);
		put_sprite(1, 1'b1, 2'd3, 2'd0, 6'h27, 9'd200, 9'd30);
		run_line(2, "16x16 and 32x32 addressing", 9'd44, 319);

		@(negedge clk);
		clear_records();
		put_sprite(2, 1'b1, 2'd0, 2'd0, 6'd2, 9'd150, 9'd10);
		put_sprite(7, 1'b1, 2'd1, 2'd1, 6'd3, 9'd160, 9'd12);
		put_sprite(9, 1'b1, 2'd2, 2'd2, 6'd1, 9'd170, 9'd14);
		run_line(3, "overlap and transparency", 9'd19, 319);

		// Only sprite 4 is drawn
		@(negedge clk);
		clear_records();
		put_sprite(0, 1'b0, 2'd1, 2'd2, 6'd1, 9'd100, 9'd50);
		put_sprite(1, 1'b1, 2'd1, 2'd3, 6'd1, 9'd120, 9'd55);
		put_sprite(2, 1'b1, 2'd2, 2'd1, 6'd2, 9'd140, 9'd60);
		put_sprite(3, 1'b1, 2'd3, 2'd2, 6'd3, 9'd160, 9'd40);
		put_sprite(4, 1'b1, 2'd0, 2'd2, 6'd4, 9'd300, 9'd55);
		run_line(4, "disabled, none and off-line", 9'd54, 319);

		@(negedge clk);
		clear_records();
		run_line(5, "empty line after sprites", 9'd54, 319);

		// Full hcnt range reaches the wrapped low positions
		@(negedge clk);
		clear_records();
		put_sprite(0, 1'b1, 2'd1, 2'd0, 6'd4, 9'd496, 9'd100);
		put_sprite(1, 1'b1, 2'd2, 2'd1, 6'd6, 9'd505, 9'd100);
		run_line(6, "wrap at x 511", 9'd107, 511);

		$display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
			NUM_TESTS, failed_tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
